/* files.f */
logic/sram_pkg.sv
logic/sram_cmd_seq.sv
logic/sram_resp_fifo.sv
logic/sram_resp_out.sv
logic/sram_pad_io.sv
logic/sram_ctrl_top.sv
dv/sram_chip_model.sv
dv/tb_sram_ctrl.sv

/* run.sh */
#!/bin/sh
# build and run the SRAM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module tb_sram_ctrl -o tb_sram_ctrl
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

out=$(./obj_dir/tb_sram_ctrl)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "test passed"; then
  exit 0
fi
exit 1

/* dv/tb_sram_ctrl.sv */
`timescale 1ns/1ps

module tb_sram_ctrl;
  import sram_pkg::*;

  // roughly 1500 cycles of traffic, so 4000 leaves ample margin
  localparam int max_cycles = 4000;
  localparam int seed_init = 32'hc8a9_cbd1;

  logic clk;
  logic rst_n;
  logic cmd_valid;
  logic cmd_ready;
  sram_addr_t cmd_addr;
  logic cmd_wr_en;
  sram_data_t cmd_wr_data;
  sram_meta_t cmd_meta;
  logic cmd_last;
  logic resp_valid;
  logic resp_ready;
  sram_meta_t resp_meta;
  logic resp_last;
  sram_data_t resp_rd_data;
  sram_addr_t sram_io_addr;
  wire sram_data_t sram_io_data;
  logic sram_io_we_n;
  logic sram_io_oe_n;
  logic sram_io_ce_n;

  int seed;
  int ready_seed;
  int cycles = 0;
  logic toggle_ready;
  string test_name;

  // memory mirror and expected responses in command order
  sram_data_t mirror [sram_addr_t];
  sram_meta_t exp_meta [$];
  logic exp_last [$];
  sram_data_t exp_data [$];
  logic exp_wr [$];
  sram_addr_t exp_wr_addr [$];

  sram_ctrl_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .cmd_addr     (cmd_addr),
    .cmd_wr_en    (cmd_wr_en),
    .cmd_wr_data  (cmd_wr_data),
    .cmd_meta     (cmd_meta),
    .cmd_last     (cmd_last),
    .resp_valid   (resp_valid),
    .resp_ready   (resp_ready),
    .resp_meta    (resp_meta),
    .resp_last    (resp_last),
    .resp_rd_data (resp_rd_data),
    .sram_io_addr (sram_io_addr),
    .sram_io_data (sram_io_data),
    .sram_io_we_n (sram_io_we_n),
    .sram_io_oe_n (sram_io_oe_n),
    .sram_io_ce_n (sram_io_ce_n)
  );

  sram_chip_model i_chip (
    .addr (sram_io_addr),
    .data (sram_io_data),
    .we_n (sram_io_we_n),
    .oe_n (sram_io_oe_n),
    .ce_n (sram_io_ce_n)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_meta(input string name, input sram_meta_t exp, input sram_meta_t act);
    if (exp !== act) begin
      fail_run($sformatf("mismatch %s meta expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_data(input string name, input sram_data_t exp, input sram_data_t act);
    if (exp !== act) begin
      fail_run($sformatf("mismatch %s data expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_addr(input string name, input sram_addr_t exp, input sram_addr_t act);
    if (exp !== act) begin
      fail_run($sformatf("mismatch %s addr expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      fail_run($sformatf("mismatch %s bit expected %b actual %b", name, exp, act));
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      fail_run($sformatf("timeout, run still busy after %0d cycles", max_cycles));
    end
  end

  // compare every response taken by the testbench against the queue head
  always @(posedge clk) begin
    if (rst_n && resp_valid && resp_ready) begin
      if (exp_meta.size() == 0) begin
        fail_run("response arrived with no command outstanding");
      end else begin
        check_meta(test_name, exp_meta.pop_front(), resp_meta);
        check_bit(test_name, exp_last.pop_front(), resp_last);
        if (!exp_wr.pop_front()) begin
          check_data(test_name, exp_data[0], resp_rd_data);
        end
        void'(exp_data.pop_front());
      end
    end
  end

  // each write pulse on the pins carries the address of the oldest write
  always @(posedge clk) begin
    if (rst_n && !sram_io_we_n) begin
      if (exp_wr_addr.size() == 0) begin
        fail_run("write strobe on the pins with no write command outstanding");
      end else begin
        check_addr(test_name, exp_wr_addr.pop_front(), sram_io_addr);
      end
    end
  end

  // random ready pattern high about three cycles in four
  always @(posedge clk) begin
    if (toggle_ready) begin
      #1;
      resp_ready = ($random(ready_seed) & 3) != 0;
    end
  end

  task automatic load_cmd(input sram_addr_t addr, input logic wr, input sram_data_t data,
                          input sram_meta_t meta, input logic last);
    cmd_addr = addr;
    cmd_wr_en = wr;
    cmd_wr_data = data;
    cmd_meta = meta;
    cmd_last = last;
  endtask

  // called on the edge that accepts the loaded command
  task automatic record_accept();
    if (cmd_wr_en) begin
      mirror[cmd_addr] = cmd_wr_data;
      exp_wr_addr.push_back(cmd_addr);
    end
    exp_meta.push_back(cmd_meta);
    exp_last.push_back(cmd_last);
    exp_wr.push_back(cmd_wr_en);
    exp_data.push_back(cmd_wr_en ? '0 : mirror[cmd_addr]);
  endtask

  task automatic send_cmd(input sram_addr_t addr, input logic wr, input sram_data_t data,
                          input sram_meta_t meta, input logic last);
    load_cmd(addr, wr, data, meta, last);
    cmd_valid = 1'b1;
    do begin
      @(posedge clk);
    end while (!cmd_ready);
    record_accept();
    #1;
    cmd_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_meta.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  // reads only hit addresses that were written before
  task automatic random_cmds(input int n);
    sram_addr_t addr;
    sram_data_t data;
    logic wr;
    for (int i = 0; i < n; i++) begin
      addr = 16'h2000 | (sram_addr_t'($random(seed)) & 16'h001f);
      data = sram_data_t'($random(seed));
      wr = 1'($random(seed));
      if (!mirror.exists(addr)) begin
        wr = 1'b1;
      end
      send_cmd(addr, wr, data, sram_meta_t'(i), (i % 4) == 3);
    end
  endtask

  task automatic reset_state_test();
    test_name = "reset_state";
    check_bit(test_name, 1'b0, resp_valid);
    check_bit(test_name, 1'b1, sram_io_we_n);
    check_bit(test_name, 1'b1, sram_io_oe_n);
    check_bit(test_name, 1'b1, sram_io_ce_n);
    check_bit(test_name, 1'b0, i_dut.i_pad.drive);
  endtask

  task automatic write_read_test();
    test_name = "write_read";
    resp_ready = 1'b1;
    for (int i = 0; i < 6; i++) begin
      send_cmd(16'h0100 + 16'(i * 'h111), 1'b1, sram_data_t'($random(seed)),
               sram_meta_t'(i), i == 5);
    end
    // read back in reverse order
    for (int i = 5; i >= 0; i--) begin
      send_cmd(16'h0100 + 16'(i * 'h111), 1'b0, '0, sram_meta_t'(8 + i), i == 0);
    end
    wait_drain();
  endtask

  task automatic random_stream_test();
    test_name = "random_stream";
    resp_ready = 1'b1;
    random_cmds(200);
    wait_drain();
  endtask

  task automatic backpressure_test();
    int accepted;
    int idle;
    sram_meta_t held_meta;
    sram_data_t held_data;
    logic held_last;
    test_name = "backpressure";
    resp_ready = 1'b0;
    accepted = 0;
    idle = 0;
    load_cmd(16'h2000 + 16'(accepted), 1'b1, sram_data_t'($random(seed)), '0, 1'b0);
    cmd_valid = 1'b1;
    // keep offering writes until the credit has stayed closed a while
    while (idle < 20) begin
      @(posedge clk);
      if (cmd_ready) begin
        record_accept();
        accepted++;
        idle = 0;
        #1;
        load_cmd(16'h2000 + 16'(accepted), 1'b1, sram_data_t'($random(seed)),
                 sram_meta_t'(accepted), 1'b0);
      end else begin
        idle++;
      end
    end
    #1;
    cmd_valid = 1'b0;
    if (accepted == 0 || accepted > resp_fifo_depth + 1) begin
      fail_run($sformatf("%0d commands accepted with responses stalled", accepted));
    end
    check_bit(test_name, 1'b1, resp_valid);
    check_meta(test_name, exp_meta[0], resp_meta);
    held_meta = resp_meta;
    held_data = resp_rd_data;
    held_last = resp_last;
    repeat (8) @(posedge clk);
    #1;
    check_bit(test_name, 1'b1, resp_valid);
    check_meta(test_name, held_meta, resp_meta);
    check_data(test_name, held_data, resp_rd_data);
    check_bit(test_name, held_last, resp_last);
    resp_ready = 1'b1;
    wait_drain();
  endtask

  task automatic ready_toggle_test();
    test_name = "ready_toggle";
    toggle_ready = 1'b1;
    random_cmds(200);
    toggle_ready = 1'b0;
    @(posedge clk);
    #1;
    resp_ready = 1'b1;
    wait_drain();
  endtask

  initial begin
    seed = seed_init;
    ready_seed = ~seed_init;
    toggle_ready = 1'b0;
    test_name = "reset";
    rst_n = 1'b0;
    cmd_valid = 1'b0;
    resp_ready = 1'b0;
    load_cmd('0, 1'b0, '0, '0, 1'b0);
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    reset_state_test();
    write_read_test();
    random_stream_test();
    backpressure_test();
    ready_toggle_test();
    $display("test passed");
    $finish;
  end

endmodule

/* dv/sram_chip_model.sv */
`timescale 1ns/1ps

module sram_chip_model (
  input  sram_pkg::sram_addr_t      addr,
  inout  wire sram_pkg::sram_data_t data,
  input  logic                      we_n,
  input  logic                      oe_n,
  input  logic                      ce_n
);
  import sram_pkg::*;

  sram_data_t mem [2**sram_addr_w];

  // read path is purely combinational, like the real part
  assign data = (!ce_n && !oe_n && we_n) ? mem[addr] : 'z;

  // the write lands on the rising edge of we_n
  always @(posedge we_n) begin
    mem[addr] <= data;
  end

endmodule

/* logic/sram_ctrl_top.sv */
`timescale 1ns/1ps

module sram_ctrl_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cmd_valid,
  output logic                 cmd_ready,
  input  sram_pkg::sram_addr_t cmd_addr,
  input  logic                 cmd_wr_en,
  input  sram_pkg::sram_data_t cmd_wr_data,
  input  sram_pkg::sram_meta_t cmd_meta,
  input  logic                 cmd_last,
  output logic                 resp_valid,
  input  logic                 resp_ready,
  output sram_pkg::sram_meta_t resp_meta,
  output logic                 resp_last,
  output sram_pkg::sram_data_t resp_rd_data,
  output sram_pkg::sram_addr_t sram_io_addr,
  inout  wire  sram_pkg::sram_data_t sram_io_data,
  output logic                 sram_io_we_n,
  output logic                 sram_io_oe_n,
  output logic                 sram_io_ce_n
);
  import sram_pkg::*;

  // sequencer to pad driver
  sram_addr_t pad_addr;
  sram_data_t pad_wr_data;
  logic pad_wr_en;
  logic pad_oe_n;
  logic pad_we_n;
  logic pad_done;
  sram_data_t pad_rd_data;

  // completed responses
  logic fifo_push;
  sram_meta_t fifo_wr_meta;
  logic fifo_wr_last;
  sram_data_t fifo_wr_data;
  fifo_count_t fifo_count;
  logic fifo_pop;
  logic fifo_empty;
  sram_meta_t fifo_rd_meta;
  logic fifo_rd_last;
  sram_data_t fifo_rd_data;

  sram_cmd_seq i_seq (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_valid    (cmd_valid),
    .cmd_wr_en    (cmd_wr_en),
    .cmd_last     (cmd_last),
    .cmd_addr     (cmd_addr),
    .cmd_wr_data  (cmd_wr_data),
    .cmd_meta     (cmd_meta),
    .cmd_ready    (cmd_ready),
    .pad_addr     (pad_addr),
    .pad_wr_data  (pad_wr_data),
    .pad_wr_en    (pad_wr_en),
    .pad_oe_n     (pad_oe_n),
    .pad_we_n     (pad_we_n),
    .pad_done     (pad_done),
    .pad_rd_data  (pad_rd_data),
    .fifo_count   (fifo_count),
    .fifo_push    (fifo_push),
    .fifo_wr_last (fifo_wr_last),
    .fifo_wr_meta (fifo_wr_meta),
    .fifo_wr_data (fifo_wr_data)
  );

  sram_resp_fifo i_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push    (fifo_push),
    .wr_meta (fifo_wr_meta),
    .wr_last (fifo_wr_last),
    .wr_data (fifo_wr_data),
    .pop     (fifo_pop),
    .empty   (fifo_empty),
    .count   (fifo_count),
    .rd_meta (fifo_rd_meta),
    .rd_last (fifo_rd_last),
    .rd_data (fifo_rd_data)
  );

  sram_resp_out i_out (
    .clk          (clk),
    .rst_n        (rst_n),
    .fifo_empty   (fifo_empty),
    .fifo_meta    (fifo_rd_meta),
    .fifo_last    (fifo_rd_last),
    .fifo_data    (fifo_rd_data),
    .fifo_pop     (fifo_pop),
    .resp_valid   (resp_valid),
    .resp_ready   (resp_ready),
    .resp_meta    (resp_meta),
    .resp_last    (resp_last),
    .resp_rd_data (resp_rd_data)
  );

  sram_pad_io i_pad (
    .clk          (clk),
    .rst_n        (rst_n),
    .pad_addr     (pad_addr),
    .pad_wr_data  (pad_wr_data),
    .pad_wr_en    (pad_wr_en),
    .pad_oe_n     (pad_oe_n),
    .pad_we_n     (pad_we_n),
    .pad_done     (pad_done),
    .pad_rd_data  (pad_rd_data),
    .sram_io_addr (sram_io_addr),
    .sram_io_data (sram_io_data),
    .sram_io_we_n (sram_io_we_n),
    .sram_io_oe_n (sram_io_oe_n),
    .sram_io_ce_n (sram_io_ce_n)
  );

endmodule

/* logic/sram_pad_io.sv */
`timescale 1ns/1ps

module sram_pad_io (
  input  logic                 clk,
  input  logic                 rst_n,
  input  sram_pkg::sram_addr_t pad_addr,
  input  sram_pkg::sram_data_t pad_wr_data,
  input  logic                 pad_wr_en,
  input  logic                 pad_oe_n,
  input  logic                 pad_we_n,
  output logic                 pad_done,
  output sram_pkg::sram_data_t pad_rd_data,
  output sram_pkg::sram_addr_t sram_io_addr,
  inout  wire  sram_pkg::sram_data_t sram_io_data,
  output logic                 sram_io_we_n,
  output logic                 sram_io_oe_n,
  output logic                 sram_io_ce_n
);
  import sram_pkg::*;

  logic req;
  logic rd_hold;
  logic drive;
  sram_data_t wr_data_q;

  // one bit per cycle since the request strobe
  logic [pad_latency-1:0] op_line;

  assign req = !pad_oe_n || !pad_we_n;

  // release the bus whenever no write is in progress
  assign sram_io_data = drive ? wr_data_q : 'z;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sram_io_we_n <= 1'b1;
      sram_io_oe_n <= 1'b1;
      sram_io_ce_n <= 1'b1;
      rd_hold <= 1'b0;
      drive <= 1'b0;
      op_line <= '0;
    end else begin
      // we_n pulses for one cycle, address and data hold past its rising edge
      sram_io_we_n <= pad_we_n;
      // oe_n stays low an extra cycle so the bus is valid at capture
      sram_io_oe_n <= pad_oe_n && !rd_hold;
      sram_io_ce_n <= !(req || op_line[0]);
      rd_hold <= !pad_oe_n;
      drive <= pad_wr_en;
      op_line <= {op_line[pad_latency-2:0], req};
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      sram_io_addr <= pad_addr;
    end
    if (pad_wr_en) begin
      wr_data_q <= pad_wr_data;
    end
    // capture on the same edge that raises pad_done
    if (op_line[pad_latency-2]) begin
      pad_rd_data <= sram_io_data;
    end
  end

  assign pad_done = op_line[pad_latency-1];

  // read and write strobes from the sequencer never overlap on the pins
  assert property (@(posedge clk) disable iff (!rst_n) sram_io_oe_n || sram_io_we_n);

endmodule

/* logic/sram_resp_out.sv */
`timescale 1ns/1ps

module sram_resp_out (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fifo_empty,
  input  sram_pkg::sram_meta_t fifo_meta,
  input  logic                 fifo_last,
  input  sram_pkg::sram_data_t fifo_data,
  output logic                 fifo_pop,
  output logic                 resp_valid,
  input  logic                 resp_ready,
  output sram_pkg::sram_meta_t resp_meta,
  output logic                 resp_last,
  output sram_pkg::sram_data_t resp_rd_data
);
  import sram_pkg::*;

  logic slot_free;

  // slot is free when empty or being taken this cycle
  assign slot_free = !resp_valid || resp_ready;
  assign fifo_pop = slot_free && !fifo_empty;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
    end else if (slot_free) begin
      resp_valid <= !fifo_empty;
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_pop) begin
      resp_meta <= fifo_meta;
      resp_last <= fifo_last;
      resp_rd_data <= fifo_data;
    end
  end

  // a stalled response keeps every field until it is taken
  assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_meta)
      && $stable(resp_last) && $stable(resp_rd_data));

endmodule

/* logic/sram_resp_fifo.sv */
`timescale 1ns/1ps

module sram_resp_fifo (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  push,
  input  sram_pkg::sram_meta_t  wr_meta,
  input  logic                  wr_last,
  input  sram_pkg::sram_data_t  wr_data,
  input  logic                  pop,
  output logic                  empty,
  output sram_pkg::fifo_count_t count,
  output sram_pkg::sram_meta_t  rd_meta,
  output logic                  rd_last,
  output sram_pkg::sram_data_t  rd_data
);
  import sram_pkg::*;

  sram_meta_t meta_mem [resp_fifo_depth];
  sram_data_t data_mem [resp_fifo_depth];
  logic [resp_fifo_depth-1:0] last_mem;

  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic full;

  // wraps at the depth, which need not be a power of two
  function automatic logic [fifo_ptr_w-1:0] ptr_inc(input logic [fifo_ptr_w-1:0] ptr);
    if (ptr == fifo_ptr_w'(resp_fifo_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty = count == '0;
  assign full = count == fifo_count_w'(resp_fifo_depth);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      meta_mem[wr_ptr] <= wr_meta;
      data_mem[wr_ptr] <= wr_data;
      last_mem[wr_ptr] <= wr_last;
    end
  end

  // head entry is visible without a pop
  assign rd_meta = meta_mem[rd_ptr];
  assign rd_data = data_mem[rd_ptr];
  assign rd_last = last_mem[rd_ptr];

  // the sequencer credit keeps pushes within the depth
  assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);

  // the output stage only pops a present entry
  assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

/* logic/sram_cmd_seq.sv */
`timescale 1ns/1ps

module sram_cmd_seq (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_valid,
  input  logic                  cmd_wr_en,
  input  logic                  cmd_last,
  input  sram_pkg::sram_addr_t  cmd_addr,
  input  sram_pkg::sram_data_t  cmd_wr_data,
  input  sram_pkg::sram_meta_t  cmd_meta,
  output logic                  cmd_ready,
  output sram_pkg::sram_addr_t  pad_addr,
  output sram_pkg::sram_data_t  pad_wr_data,
  output logic                  pad_wr_en,
  output logic                  pad_oe_n,
  output logic                  pad_we_n,
  input  logic                  pad_done,
  input  sram_pkg::sram_data_t  pad_rd_data,
  input  sram_pkg::fifo_count_t fifo_count,
  output logic                  fifo_push,
  output logic                  fifo_wr_last,
  output sram_pkg::sram_meta_t  fifo_wr_meta,
  output sram_pkg::sram_data_t  fifo_wr_data
);
  import sram_pkg::*;

  seq_state_t state;
  seq_state_t state_next;

  logic accept;
  logic credit_ok;
  fifo_count_t inflight;
  logic [fifo_count_w:0] credit_used;

  // tag of the request currently on the pad strobes
  logic req_valid;
  sram_meta_t req_meta;
  logic req_last;

  // in-flight tags with the head lined up on pad_done
  logic [pad_latency-1:0] pipe_valid;
  logic [pad_latency-1:0] pipe_last;
  sram_meta_t pipe_meta [pad_latency];

  // every response in flight or queued holds one fifo slot
  assign credit_used = {1'b0, inflight} + {1'b0, fifo_count};
  assign credit_ok = credit_used < resp_fifo_depth;

  assign cmd_ready = (state == seq_idle) && credit_ok;
  assign accept = cmd_valid && cmd_ready;

  always_comb begin
    state_next = state;
    case (state)
      seq_idle: begin
        if (accept) begin
          state_next = cmd_wr_en ? seq_write : seq_read;
        end
      end
      seq_read: state_next = seq_idle;
      seq_write: state_next = seq_idle;
      default: state_next = seq_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= seq_idle;
    end else begin
      state <= state_next;
    end
  end

  // address, data and tag captured on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      pad_addr <= cmd_addr;
      req_meta <= cmd_meta;
      req_last <= cmd_last;
    end
    if (accept && cmd_wr_en) begin
      pad_wr_data <= cmd_wr_data;
    end
  end

  // single cycle request strobes
  // bus enable spans the write state too
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pad_oe_n <= 1'b1;
      pad_we_n <= 1'b1;
      pad_wr_en <= 1'b0;
    end else begin
      pad_oe_n <= state_next != seq_read;
      pad_we_n <= state_next != seq_write;
      pad_wr_en <= (state_next == seq_write) || (state == seq_write);
    end
  end

  assign req_valid = !pad_oe_n || !pad_we_n;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pipe_valid <= '0;
    end else begin
      pipe_valid <= {pipe_valid[pad_latency-2:0], req_valid};
    end
  end

  always_ff @(posedge clk) begin
    pipe_meta[0] <= req_meta;
    pipe_last <= {pipe_last[pad_latency-2:0], req_last};
    for (int i = 1; i < pad_latency; i++) begin
      pipe_meta[i] <= pipe_meta[i-1];
    end
  end

  // operations between acceptance and their fifo push
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      inflight <= '0;
    end else begin
      case ({accept, pad_done})
        2'b10: inflight <= inflight + 1'b1;
        2'b01: inflight <= inflight - 1'b1;
        default: inflight <= inflight;
      endcase
    end
  end

  assign fifo_push = pad_done;
  assign fifo_wr_meta = pipe_meta[pad_latency-1];
  assign fifo_wr_last = pipe_last[pad_latency-1];
  assign fifo_wr_data = pad_rd_data;

  // a completion from the pad driver always finds its tag at the head
  assert property (@(posedge clk) disable iff (!rst_n)
    pad_done |-> pipe_valid[pad_latency-1]);

  // responses in flight and queued never outgrow the fifo
  assert property (@(posedge clk) disable iff (!rst_n)
    credit_used <= resp_fifo_depth);

endmodule

/* logic/sram_pkg.sv */
package sram_pkg;

  // external chip geometry
  localparam int sram_addr_w = 16;
  localparam int sram_data_w = 16;
  localparam int sram_meta_w = 4;

  // response buffering and credit limit
  localparam int resp_fifo_depth = 4;
  localparam int fifo_count_w = $clog2(resp_fifo_depth + 1);
  localparam int fifo_ptr_w = $clog2(resp_fifo_depth);

  // request strobe to completion pulse, in cycles
  localparam int pad_latency = 3;

  typedef logic [sram_addr_w-1:0] sram_addr_t;
  typedef logic [sram_data_w-1:0] sram_data_t;
  typedef logic [sram_meta_w-1:0] sram_meta_t;
  typedef logic [fifo_count_w-1:0] fifo_count_t;

  typedef enum logic [1:0] {
    seq_idle,
    seq_read,
    seq_write
  } seq_state_t;

endpackage
